/* design/serial_div_pkg.sv */
package serial_div_pkg;

    // operand width of the divider
    localparam int WORD_W = 64;

    // width of a bit-length count
    // holds 0 up to WORD_W
    localparam int LEN_W = 8;

    // dividend, divisor, quotient, remainder and difference words
    typedef logic [WORD_W-1:0] word_t;

    // number of significant bits in one operand
    typedef logic [LEN_W-1:0] len_t;

    // division controller states
    typedef enum logic [2:0] {
        // waiting for the first start after reset
        st_idle,
        // both bit-length counters running
        st_measure,
        // launch one trial subtraction
        st_trial,
        // serial subtractor busy
        st_wait_sub,
        // results valid and held
        st_done
    } div_state_t;

endpackage

/* design/len_if.sv */
`timescale 1ns/1ns

// controller to one bit-length counter
interface len_if;
    import serial_div_pkg::*;

    // one-cycle request
    logic  start;
    // operand, held stable until done
    word_t value;
    // valid on done, held afterwards
    len_t  length;
    // one-cycle completion pulse
    logic  done;

    modport ctrl (output start, value, input length, done);
    modport counter (input start, value, output length, done);

endinterface

/* design/sub_if.sv */
`timescale 1ns/1ns

// controller to the slice-serial subtractor
interface sub_if;
    import serial_div_pkg::*;

    // one-cycle request
    logic  start;
    // operands, held from start to done
    word_t minuend;
    word_t subtrahend;
    // minuend - subtrahend, valid with done
    word_t diff;
    // high when minuend >= subtrahend
    logic  no_borrow;
    // one-cycle completion pulse
    logic  done;

    modport ctrl (output start, minuend, subtrahend, input diff, no_borrow, done);
    modport sub (input start, minuend, subtrahend, output diff, no_borrow, done);

endinterface

/* design/bit_length_counter.sv */
`timescale 1ns/1ns

module bit_length_counter (
    input  logic       clk,
    input  logic       rst_n,
    len_if.counter     lif
);
    import serial_div_pkg::*;

    // running bit count, ends as msb position + 1
    len_t count;
    logic busy;
    logic done_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count  <= '0;
            busy   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            // done is a single-cycle pulse
            done_q <= 1'b0;
            if (lif.start) begin
                // new operand, restart from zero
                count <= '0;
                busy  <= 1'b1;
            end else if (busy) begin
                // bits still left above count
                if ((lif.value >> count) != '0) begin
                    count <= len_t'(count + 1'b1);
                end else begin
                    // nothing left, count is the length
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // length stays on the last count until the next start
    assign lif.length = count;
    assign lif.done   = done_q;

endmodule

/* design/serial_subtractor.sv */
`timescale 1ns/1ns

module serial_subtractor #(
    parameter int SLICE_W = 8
) (
    input  logic  clk,
    input  logic  rst_n,
    sub_if.sub    sif
);
    import serial_div_pkg::*;

    // slices per word and width of the slice index
    localparam int NSLICE = WORD_W / SLICE_W;
    localparam int IDX_W  = (NSLICE > 1) ? $clog2(NSLICE) : 1;

    logic             busy;
    logic [IDX_W-1:0] idx;
    logic             done_q;
    logic             last;

    // operand shifters, lowest slice sits at bit 0
    word_t            a_sh;
    word_t            b_sh;
    // carry between slices, 1 into slice 0 completes the two's complement
    logic             carry;
    logic [SLICE_W:0] slice_sum;

    // a + ~b + carry on the current slice
    assign slice_sum = {1'b0, a_sh[SLICE_W-1:0]}
                     + {1'b0, b_sh[SLICE_W-1:0]}
                     + {{SLICE_W{1'b0}}, carry};

    assign last = (idx == IDX_W'(NSLICE - 1));

    // slice sequencing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            idx    <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (sif.start) begin
                busy <= 1'b1;
                idx  <= '0;
            end else if (busy) begin
                idx <= idx + 1'b1;
                if (last) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // slice datapath
    always_ff @(posedge clk) begin
        if (sif.start) begin
            a_sh  <= sif.minuend;
            // subtrahend inverted once on load
            b_sh  <= ~sif.subtrahend;
            carry <= 1'b1;
        end else if (busy) begin
            a_sh  <= a_sh >> SLICE_W;
            b_sh  <= b_sh >> SLICE_W;
            carry <= slice_sum[SLICE_W];
            sif.diff[idx*SLICE_W +: SLICE_W] <= slice_sum[SLICE_W-1:0];
            // final carry out means no borrow
            if (last) begin
                sif.no_borrow <= slice_sum[SLICE_W];
            end
        end
    end

    assign sif.done = done_q;

endmodule

/* design/div_control.sv */
`timescale 1ns/1ns

module div_control (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  serial_div_pkg::word_t dividend,
    input  serial_div_pkg::word_t divisor,
    len_if.ctrl                   len_a,
    len_if.ctrl                   len_b,
    sub_if.ctrl                   sif,
    output serial_div_pkg::word_t quotient,
    output serial_div_pkg::word_t remainder,
    output logic                  ready_n
);
    import serial_div_pkg::*;

    div_state_t state;

    // captured operands
    word_t a_reg;
    word_t b_reg;

    // lengths latched from the counters' done pulses
    len_t  len_dividend;
    len_t  len_divisor;

    // current shift of the divisor, counts down to zero
    len_t  shift_amt;

    // counter done pulses seen so far
    logic  got_a;
    logic  got_b;

    // start only taken when no division is running
    logic  accept;

    assign accept = start && ((state == st_idle) || (state == st_done));

    // counters read the captured operands directly
    assign len_a.value = a_reg;
    assign len_b.value = b_reg;

    // sequencing and result registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= st_idle;
            ready_n     <= 1'b1;
            len_a.start <= 1'b0;
            len_b.start <= 1'b0;
            sif.start   <= 1'b0;
            got_a       <= 1'b0;
            got_b       <= 1'b0;
            shift_amt   <= '0;
            quotient    <= '0;
            remainder   <= '0;
        end else begin
            // request strobes are one cycle wide
            len_a.start <= 1'b0;
            len_b.start <= 1'b0;
            sif.start   <= 1'b0;
            case (state)
                st_idle, st_done: begin
                    if (accept) begin
                        // operands land in a_reg/b_reg this edge
                        ready_n     <= 1'b1;
                        len_a.start <= 1'b1;
                        len_b.start <= 1'b1;
                        got_a       <= 1'b0;
                        got_b       <= 1'b0;
                        state       <= st_measure;
                    end
                end
                st_measure: begin
                    // done pulses may come in either order
                    if (len_a.done) begin
                        got_a <= 1'b1;
                    end
                    if (len_b.done) begin
                        got_b <= 1'b1;
                    end
                    if (got_a && got_b) begin
                        remainder <= a_reg;
                        if (len_divisor == '0) begin
                            // divide by zero
                            quotient <= '1;
                            ready_n  <= 1'b0;
                            state    <= st_done;
                        end else if (len_dividend < len_divisor) begin
                            // dividend smaller than divisor
                            quotient <= '0;
                            ready_n  <= 1'b0;
                            state    <= st_done;
                        end else begin
                            // align divisor msb with dividend msb
                            quotient  <= '0;
                            shift_amt <= len_dividend - len_divisor;
                            state     <= st_trial;
                        end
                    end
                end
                st_trial: begin
                    // operands are loaded by the datapath block this edge
                    sif.start <= 1'b1;
                    state     <= st_wait_sub;
                end
                st_wait_sub: begin
                    if (sif.done) begin
                        // one quotient bit per trial, msb first
                        quotient <= {quotient[WORD_W-2:0], sif.no_borrow};
                        // restoring step, keep the difference only if it fit
                        if (sif.no_borrow) begin
                            remainder <= sif.diff;
                        end
                        if (shift_amt == '0) begin
                            ready_n <= 1'b0;
                            state   <= st_done;
                        end else begin
                            shift_amt <= shift_amt - 1'b1;
                            state     <= st_trial;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // operand and length capture
    always_ff @(posedge clk) begin
        if (accept) begin
            a_reg <= dividend;
            b_reg <= divisor;
        end
        if (len_a.done) begin
            len_dividend <= len_a.length;
        end
        if (len_b.done) begin
            len_divisor <= len_b.length;
        end
        // trial operands held until the subtractor finishes
        if (state == st_trial) begin
            sif.minuend    <= remainder;
            sif.subtrahend <= b_reg << shift_amt;
        end
    end

endmodule

/* design/serial_div_top.sv */
`timescale 1ns/1ns

module serial_div_top #(
    // subtractor slice width, any divisor of 64
    parameter int SLICE_W = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  serial_div_pkg::word_t dividend,
    input  serial_div_pkg::word_t divisor,
    output serial_div_pkg::word_t quotient,
    output serial_div_pkg::word_t remainder,
    output logic                  ready_n
);

    // one length bus per operand
    len_if len_dividend_if ();
    len_if len_divisor_if ();

    // trial subtraction bus
    sub_if sub_bus ();

    // dividend bit length
    bit_length_counter i_len_dividend (
        .clk   (clk),
        .rst_n (rst_n),
        .lif   (len_dividend_if.counter)
    );

    // divisor bit length, runs alongside the dividend counter
    bit_length_counter i_len_divisor (
        .clk   (clk),
        .rst_n (rst_n),
        .lif   (len_divisor_if.counter)
    );

    // shared by every trial subtraction
    serial_subtractor #(
        .SLICE_W (SLICE_W)
    ) i_sub (
        .clk   (clk),
        .rst_n (rst_n),
        .sif   (sub_bus.sub)
    );

    // measure, then shift-subtract loop
    div_control i_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .dividend  (dividend),
        .divisor   (divisor),
        .len_a     (len_dividend_if.ctrl),
        .len_b     (len_divisor_if.ctrl),
        .sif       (sub_bus.ctrl),
        .quotient  (quotient),
        .remainder (remainder),
        .ready_n   (ready_n)
    );

endmodule

/* tb/serial_div_tb.sv */
`timescale 1ns/1ns

module serial_div_tb;
    import serial_div_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int HOLD_CYCLES  = 20;
    localparam int NUM_RANDOM   = 200;
    // random + short/equal + full width + zero divisor + ignored start
    localparam int NUM_DIV      = NUM_RANDOM + 4 + 4 + 2 + 1;
    // worst case near 65 + 65*10 cycles per division
    localparam int TIMEOUT_CYCLES = NUM_DIV * 1000 + 100;
    localparam int unsigned SEED  = 32'h167698e4;

    logic  clk;
    logic  rst_n;
    logic  start;
    word_t dividend;
    word_t divisor;
    word_t quotient;
    word_t remainder;
    logic  ready_n;

    // expected results with one entry per accepted start
    word_t exp_quot[$];
    word_t exp_rem[$];
    int    n_issued;
    int    n_checked;

    serial_div_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .dividend  (dividend),
        .divisor   (divisor),
        .quotient  (quotient),
        .remainder (remainder),
        .ready_n   (ready_n)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // unsigned division with all ones and the dividend back for a zero divisor
    function automatic void ref_divide(input word_t a, input word_t b,
                                       output word_t q, output word_t r);
        if (b == '0) begin
            q = '1;
            r = a;
        end else begin
            q = a / b;
            r = a % b;
        end
    endfunction

    // random word of exactly len significant bits
    function automatic word_t random_operand(input len_t len);
        word_t raw;
        word_t mask;
        raw[63:32] = $urandom();
        raw[31:0]  = $urandom();
        if (len == '0) begin
            return '0;
        end
        if (len >= len_t'(WORD_W)) begin
            mask = '1;
        end else begin
            mask = (word_t'(1) << len) - word_t'(1);
        end
        // force the top bit so the length is exact
        return (raw & mask) | (word_t'(1) << (len - len_t'(1)));
    endfunction

    task automatic check_word(input string name, input word_t exp_val, input word_t act_val);
        if (act_val !== exp_val) begin
            $display("Fail %s: expected %h, got %h", name, exp_val, act_val);
            $display("TEST FAILED");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_ready(input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("Fail ready_n: expected %h, got %h", exp_val, act_val);
            $display("TEST FAILED");
            $fatal(1, "ready_n mismatch");
        end
    endtask

    // pulse start for one cycle and queue the expected result
    task automatic issue_division(input word_t a, input word_t b);
        word_t q_ref;
        word_t r_ref;
        @(negedge clk);
        start    = 1'b1;
        dividend = a;
        divisor  = b;
        ref_divide(a, b, q_ref, r_ref);
        exp_quot.push_back(q_ref);
        exp_rem.push_back(r_ref);
        n_issued++;
        @(negedge clk);
        start = 1'b0;
        // start taken on the last edge so busy now
        check_ready(1'b1, ready_n);
    endtask

    // n_checked changes on falling edges only so read it on rising ones
    task automatic wait_results();
        while (n_checked != n_issued) begin
            @(posedge clk);
        end
    endtask

    task automatic run_division(input word_t a, input word_t b);
        issue_division(a, b);
        wait_results();
    endtask

    // compares on every falling edge of ready_n
    initial begin : compare_results
        logic  prev_ready_n;
        word_t q_ref;
        word_t r_ref;
        prev_ready_n = 1'b1;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            if (prev_ready_n && !ready_n) begin
                if (exp_quot.size() == 0) begin
                    $display("ready_n went low although no division was started");
                    $display("TEST FAILED");
                    $fatal(1, "unexpected completion");
                end else begin
                    q_ref = exp_quot.pop_front();
                    r_ref = exp_rem.pop_front();
                    check_word("quotient", q_ref, quotient);
                    check_word("remainder", r_ref, remainder);
                    n_checked++;
                end
            end
            prev_ready_n = ready_n;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("TEST FAILED");
                $fatal(1, "simulation timed out");
            end
        end
    end

    initial begin : stimulus
        len_t  len_a;
        len_t  len_b;
        word_t a6;
        word_t b6;
        word_t q6;
        word_t r6;
        void'($urandom(SEED));
        n_issued  = 0;
        n_checked = 0;
        rst_n     = 1'b0;
        start     = 1'b0;
        dividend  = '0;
        divisor   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle after reset before any start
        repeat (3) begin
            @(negedge clk);
            check_ready(1'b1, ready_n);
            check_word("quotient", '0, quotient);
            check_word("remainder", '0, remainder);
        end

        // random lengths including some zero divisors
        for (int i = 0; i < NUM_RANDOM; i++) begin
            len_a = len_t'($urandom_range(WORD_W, 0));
            len_b = len_t'($urandom_range(WORD_W, 0));
            run_division(random_operand(len_a), random_operand(len_b));
        end

        // dividend shorter than divisor
        run_division(64'd5, 64'd1000);
        run_division(64'h0000_0000_0000_00ff, 64'h0000_0001_0000_0000);
        // equal operands
        run_division(64'd7, 64'd7);
        run_division(64'h8000_0000_0000_0001, 64'h8000_0000_0000_0001);

        // full width cases where the msb of the difference is not a borrow
        run_division(64'hffff_ffff_ffff_ffff, 64'd1);
        run_division(64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff);
        run_division(64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000);
        run_division(64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff);

        // divide by zero
        run_division(64'hdead_beef_0123_4567, 64'd0);
        run_division(64'd0, 64'd0);

        // long division with stray starts while busy
        a6 = 64'hffff_ffff_ffff_fff0;
        b6 = 64'd3;
        ref_divide(a6, b6, q6, r6);
        issue_division(a6, b6);
        // first stray start while the lengths are measured
        @(negedge clk);
        start    = 1'b1;
        dividend = ~a6;
        divisor  = 64'd5;
        check_ready(1'b1, ready_n);
        @(negedge clk);
        start = 1'b0;
        // measuring takes about 70 cycles, the loop about 700 more
        repeat (200) @(negedge clk);
        // second stray start inside the subtract loop
        check_ready(1'b1, ready_n);
        start    = 1'b1;
        dividend = 64'd100;
        divisor  = 64'd9;
        @(negedge clk);
        start = 1'b0;
        wait_results();

        // results and ready_n are held levels
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_ready(1'b0, ready_n);
            check_word("quotient", q6, quotient);
            check_word("remainder", r6, remainder);
        end

        repeat (2) @(negedge clk);
        if (n_checked == NUM_DIV && exp_quot.size() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("only %0d of %0d divisions were checked", n_checked, NUM_DIV);
            $display("TEST FAILED");
            $fatal(1, "division count mismatch");
        end
    end

endmodule

/* serial_div.f */
design/serial_div_pkg.sv
design/len_if.sv
design/sub_if.sv
design/bit_length_counter.sv
design/serial_subtractor.sv
design/div_control.sv
design/serial_div_top.sv
tb/serial_div_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the serial divider testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module serial_div_tb \
    -f serial_div.f -o serial_div_sim > build.log 2>&1 \
    && ./obj_dir/serial_div_sim > sim.log 2>&1

# the log decides, not the exit code of the simulator
grep -q "^TEST PASSED$" sim.log 2>/dev/null \
    && echo "simulation passed" \
    && exit 0 \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
